// ==== source/frontend_pkg.sv ====
package frontend_pkg;

    localparam int XLEN       = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;
    localparam int FIFO_DEPTH = 4;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef enum logic [3:0] {
        cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch,
        cls_load, cls_store, cls_op_imm, cls_op, cls_illegal
    } inst_class_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic [3:0] {
        mem_none, mem_lb, mem_lh, mem_lw, mem_lbu,
        mem_lhu, mem_sb, mem_sh, mem_sw
    } mem_op_e;

    typedef enum logic [2:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu
    } br_cond_e;

    typedef enum logic [1:0] {
        opa_rs1, opa_pc, opa_zero
    } opa_sel_e;

    typedef enum logic [1:0] {
        opb_rs2, opb_imm, opb_four
    } opb_sel_e;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
    } fetch_pkt_t;

    typedef struct packed {
        inst_class_e     inst_class;
        alu_op_e         alu_op;
        mem_op_e         mem_op;
        br_cond_e        br_cond;
        logic [XLEN-1:0] imm;
        opa_sel_e        opa_sel;
        opb_sel_e        opb_sel;
        logic [4:0]      rd;
        logic            gpr_we;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
    } dec_pkt_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] next_pc;
        alu_op_e         alu_op;
        mem_op_e         mem_op;
        logic [XLEN-1:0] opr_a;
        logic [XLEN-1:0] opr_b;
        logic [XLEN-1:0] store_data;
        logic [4:0]      rd;
        logic            gpr_we;
        logic            illegal;
        logic            taken;     // Branch or jump redirects the PC
    } exec_pkt_t;

endpackage

// ==== source/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  frontend_pkg::fetch_pkt_t in_pkt,
    output logic                     dec_valid,
    output frontend_pkg::dec_pkt_t   dec_pkt,
    input  logic                     fifo_full
);
    import frontend_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [4:0]      rd;
    logic            alt;        // inst[30], picks sub and sra
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    alu_op_e         arith_op;
    dec_pkt_t        dec_next;

    assign opcode = in_pkt.inst[6:0];
    assign funct3 = in_pkt.inst[14:12];
    assign rd     = in_pkt.inst[11:7];
    assign alt    = in_pkt.inst[30];

    // Five immediate formats, all sign extended except U
    assign imm_i = {{20{in_pkt.inst[31]}}, in_pkt.inst[31:20]};
    assign imm_s = {{20{in_pkt.inst[31]}}, in_pkt.inst[31:25], in_pkt.inst[11:7]};
    assign imm_b = {{19{in_pkt.inst[31]}}, in_pkt.inst[31], in_pkt.inst[7],
                    in_pkt.inst[30:25], in_pkt.inst[11:8], 1'b0};
    assign imm_u = {in_pkt.inst[31:12], 12'b0};
    assign imm_j = {{11{in_pkt.inst[31]}}, in_pkt.inst[31], in_pkt.inst[19:12],
                    in_pkt.inst[20], in_pkt.inst[30:21], 1'b0};

    // ALU table shared by op and op_imm
    always_comb begin
        case (funct3)
            3'd0:    arith_op = (alt && opcode == OPC_OP) ? alu_sub : alu_add;
            3'd1:    arith_op = alu_sll;
            3'd2:    arith_op = alu_slt;
            3'd3:    arith_op = alu_sltu;
            3'd4:    arith_op = alu_xor;
            3'd5:    arith_op = alt ? alu_sra : alu_srl;
            3'd6:    arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        dec_next.inst_class = cls_illegal;
        dec_next.alu_op     = alu_add;
        dec_next.mem_op     = mem_none;
        dec_next.br_cond    = br_none;
        dec_next.imm        = '0;
        dec_next.opa_sel    = opa_rs1;
        dec_next.opb_sel    = opb_rs2;
        dec_next.rd         = rd;
        dec_next.rs1_val    = in_pkt.rs1_val;
        dec_next.rs2_val    = in_pkt.rs2_val;
        case (opcode)
            OPC_LUI: begin
                dec_next.inst_class = cls_lui;
                dec_next.imm        = imm_u;
                dec_next.opa_sel    = opa_zero;
                dec_next.opb_sel    = opb_imm;
            end
            OPC_AUIPC: begin
                dec_next.inst_class = cls_auipc;
                dec_next.imm        = imm_u;
                dec_next.opa_sel    = opa_pc;
                dec_next.opb_sel    = opb_imm;
            end
            OPC_JAL, OPC_JALR: begin
                dec_next.inst_class = (opcode == OPC_JAL) ? cls_jal : cls_jalr;
                dec_next.imm        = (opcode == OPC_JAL) ? imm_j : imm_i;
                dec_next.opa_sel    = opa_pc;       // Link value is pc + 4
                dec_next.opb_sel    = opb_four;
            end
            OPC_BRANCH: begin
                dec_next.inst_class = cls_branch;
                dec_next.alu_op     = alu_sub;
                dec_next.imm        = imm_b;
                case (funct3)
                    3'd0:    dec_next.br_cond = br_eq;
                    3'd1:    dec_next.br_cond = br_ne;
                    3'd4:    dec_next.br_cond = br_lt;
                    3'd5:    dec_next.br_cond = br_ge;
                    3'd6:    dec_next.br_cond = br_ltu;
                    3'd7:    dec_next.br_cond = br_geu;
                    default: dec_next.inst_class = cls_illegal;
                endcase
            end
            OPC_LOAD: begin
                dec_next.inst_class = cls_load;
                dec_next.imm        = imm_i;
                dec_next.opb_sel    = opb_imm;
                case (funct3)
                    3'd0:    dec_next.mem_op = mem_lb;
                    3'd1:    dec_next.mem_op = mem_lh;
                    3'd2:    dec_next.mem_op = mem_lw;
                    3'd4:    dec_next.mem_op = mem_lbu;
                    3'd5:    dec_next.mem_op = mem_lhu;
                    default: dec_next.inst_class = cls_illegal;
                endcase
            end
            OPC_STORE: begin
                dec_next.inst_class = cls_store;
                dec_next.imm        = imm_s;
                dec_next.opb_sel    = opb_imm;
                case (funct3)
                    3'd0:    dec_next.mem_op = mem_sb;
                    3'd1:    dec_next.mem_op = mem_sh;
                    3'd2:    dec_next.mem_op = mem_sw;
                    default: dec_next.inst_class = cls_illegal;
                endcase
            end
            OPC_OP_IMM: begin
                dec_next.inst_class = cls_op_imm;
                dec_next.alu_op     = arith_op;
                dec_next.imm        = imm_i;
                dec_next.opb_sel    = opb_imm;
            end
            OPC_OP: begin
                dec_next.inst_class = cls_op;
                dec_next.alu_op     = arith_op;
            end
            default: dec_next.inst_class = cls_illegal;  // CSR, fence and the rest
        endcase
        // Bad funct3 falls back to a plain illegal word
        if (dec_next.inst_class == cls_illegal) begin
            dec_next.alu_op  = alu_add;
            dec_next.mem_op  = mem_none;
            dec_next.br_cond = br_none;
            dec_next.imm     = '0;
            dec_next.opa_sel = opa_rs1;
            dec_next.opb_sel = opb_rs2;
        end
        dec_next.gpr_we = (rd != 5'd0) && (dec_next.inst_class inside
            {cls_lui, cls_auipc, cls_jal, cls_jalr, cls_load, cls_op_imm, cls_op});
    end

    assign in_ready = !dec_valid || !fifo_full;   // Empty, or drained this cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            dec_valid <= 1'b1;
        end else if (!fifo_full) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec_pkt <= dec_next;
        end
    end

endmodule

// ==== source/decode_fifo.sv ====
`timescale 1ns/100ps

module decode_fifo #(
    parameter int DEPTH = frontend_pkg::FIFO_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  frontend_pkg::dec_pkt_t push_pkt,
    output logic                   full,
    input  logic                   pop,
    output frontend_pkg::dec_pkt_t head_pkt,
    output logic                   empty
);
    import frontend_pkg::*;

    dec_pkt_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    assign full     = (count == DEPTH);
    assign empty    = (count == 0);
    assign do_push  = push && !full;     // Writes into a full buffer are dropped
    assign do_pop   = pop && !empty;
    assign head_pkt = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== source/pc_sequencer.sv ====
`timescale 1ns/100ps

module pc_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fifo_empty,
    input  frontend_pkg::dec_pkt_t  head_pkt,
    output logic                    pop,
    output logic                    out_valid,
    input  logic                    out_ready,
    output frontend_pkg::exec_pkt_t out_pkt
);
    import frontend_pkg::*;

    logic [XLEN-1:0] pc;
    logic            cond;
    logic            taken;
    logic [XLEN-1:0] seq_pc;
    logic [XLEN-1:0] rel_target;
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] opr_a;
    logic [XLEN-1:0] opr_b;
    exec_pkt_t       exec_next;

    // Branch compare on the raw register values
    always_comb begin
        case (head_pkt.br_cond)
            br_eq:   cond = (head_pkt.rs1_val == head_pkt.rs2_val);
            br_ne:   cond = (head_pkt.rs1_val != head_pkt.rs2_val);
            br_lt:   cond = ($signed(head_pkt.rs1_val) < $signed(head_pkt.rs2_val));
            br_ge:   cond = ($signed(head_pkt.rs1_val) >= $signed(head_pkt.rs2_val));
            br_ltu:  cond = (head_pkt.rs1_val < head_pkt.rs2_val);
            br_geu:  cond = (head_pkt.rs1_val >= head_pkt.rs2_val);
            default: cond = 1'b0;
        endcase
    end

    assign taken = (head_pkt.inst_class == cls_jal) || (head_pkt.inst_class == cls_jalr)
                || (head_pkt.inst_class == cls_branch && cond);

    assign seq_pc     = pc + XLEN'(4);
    assign rel_target = pc + head_pkt.imm;
    assign jalr_sum   = head_pkt.rs1_val + head_pkt.imm;

    always_comb begin
        if (head_pkt.inst_class == cls_jalr) begin
            next_pc = {jalr_sum[XLEN-1:1], 1'b0};   // Target bit 0 cleared
        end else if (taken) begin
            next_pc = rel_target;
        end else begin
            next_pc = seq_pc;                       // Illegal words fall through here
        end
    end

    always_comb begin
        case (head_pkt.opa_sel)
            opa_pc:   opr_a = pc;
            opa_zero: opr_a = '0;
            default:  opr_a = head_pkt.rs1_val;
        endcase
        case (head_pkt.opb_sel)
            opb_imm:  opr_b = head_pkt.imm;
            opb_four: opr_b = XLEN'(4);
            default:  opr_b = head_pkt.rs2_val;
        endcase
    end

    always_comb begin
        exec_next.pc         = pc;
        exec_next.next_pc    = next_pc;
        exec_next.alu_op     = head_pkt.alu_op;
        exec_next.mem_op     = head_pkt.mem_op;
        exec_next.opr_a      = opr_a;
        exec_next.opr_b      = opr_b;
        exec_next.store_data = head_pkt.rs2_val;
        exec_next.rd         = head_pkt.rd;
        exec_next.gpr_we     = head_pkt.gpr_we;
        exec_next.illegal    = (head_pkt.inst_class == cls_illegal);
        exec_next.taken      = taken;
    end

    assign pop = !fifo_empty && (!out_valid || out_ready);  // Output slot free or leaving

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= RESET_PC;
            out_valid <= 1'b0;
        end else if (pop) begin
            pc        <= next_pc;
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_pkt <= exec_next;
        end
    end

endmodule

// ==== source/frontend.sv ====
`timescale 1ns/100ps

module frontend (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  frontend_pkg::fetch_pkt_t in_pkt,
    output logic                    out_valid,
    input  logic                    out_ready,
    output frontend_pkg::exec_pkt_t out_pkt
);
    import frontend_pkg::*;

    logic     dec_valid;
    dec_pkt_t dec_pkt;
    logic     fifo_full;
    logic     fifo_empty;
    dec_pkt_t head_pkt;
    logic     pop;

    inst_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .dec_valid (dec_valid),
        .dec_pkt   (dec_pkt),
        .fifo_full (fifo_full)
    );

    // Lets decode run ahead of a stalled consumer
    decode_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (dec_valid),
        .push_pkt (dec_pkt),
        .full     (fifo_full),
        .pop      (pop),
        .head_pkt (head_pkt),
        .empty    (fifo_empty)
    );

    pc_sequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .fifo_empty (fifo_empty),
        .head_pkt   (head_pkt),
        .pop        (pop),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_pkt    (out_pkt)
    );

endmodule

// ==== dv/frontend_model.svh ====
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

// Expected-value model of the front end, one call per accepted instruction

function automatic logic [XLEN-1:0] imm_i(logic [31:0] w);
    return XLEN'($signed(w[31:20]));
endfunction

function automatic logic [XLEN-1:0] imm_s(logic [31:0] w);
    return XLEN'($signed({w[31:25], w[11:7]}));
endfunction

function automatic logic [XLEN-1:0] imm_b(logic [31:0] w);
    return XLEN'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
endfunction

function automatic logic [XLEN-1:0] imm_u(logic [31:0] w);
    return {w[31:12], 12'h000};
endfunction

function automatic logic [XLEN-1:0] imm_j(logic [31:0] w);
    return XLEN'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
endfunction

// Bit 30 selects sub only for register ops, sra for both
function automatic alu_op_e arith_op_of(logic [2:0] f3, logic b30, logic is_reg);
    case (f3)
        3'd0:    return (is_reg && b30) ? alu_sub : alu_add;
        3'd1:    return alu_sll;
        3'd2:    return alu_slt;
        3'd3:    return alu_sltu;
        3'd4:    return alu_xor;
        3'd5:    return b30 ? alu_sra : alu_srl;
        3'd6:    return alu_or;
        default: return alu_and;
    endcase
endfunction

function automatic mem_op_e load_op_of(logic [2:0] f3);
    case (f3)
        3'd0:    return mem_lb;
        3'd1:    return mem_lh;
        3'd2:    return mem_lw;
        3'd4:    return mem_lbu;
        3'd5:    return mem_lhu;
        default: return mem_none;     // Undefined width
    endcase
endfunction

function automatic mem_op_e store_op_of(logic [2:0] f3);
    case (f3)
        3'd0:    return mem_sb;
        3'd1:    return mem_sh;
        3'd2:    return mem_sw;
        default: return mem_none;
    endcase
endfunction

function automatic logic branch_holds(logic [2:0] f3, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        default: return a >= b;
    endcase
endfunction

function automatic exec_pkt_t expected_exec(fetch_pkt_t f, logic [XLEN-1:0] pc);
    exec_pkt_t  e;
    logic [6:0] opc;
    logic [2:0] f3;
    logic       bad;
    opc = f.inst[6:0];
    f3  = f.inst[14:12];
    bad = 1'b0;
    e.pc         = pc;
    e.next_pc    = pc + 32'd4;
    e.alu_op     = alu_add;
    e.mem_op     = mem_none;
    e.opr_a      = f.rs1_val;
    e.opr_b      = f.rs2_val;
    e.store_data = f.rs2_val;
    e.rd         = f.inst[11:7];
    e.gpr_we     = 1'b0;
    e.illegal    = 1'b0;
    e.taken      = 1'b0;
    case (opc)
        OPC_LUI: begin
            e.opr_a  = '0;
            e.opr_b  = imm_u(f.inst);
            e.gpr_we = 1'b1;
        end
        OPC_AUIPC: begin
            e.opr_a  = pc;
            e.opr_b  = imm_u(f.inst);
            e.gpr_we = 1'b1;
        end
        OPC_JAL: begin
            e.opr_a   = pc;
            e.opr_b   = 32'd4;
            e.taken   = 1'b1;
            e.next_pc = pc + imm_j(f.inst);
            e.gpr_we  = 1'b1;
        end
        OPC_JALR: begin
            e.opr_a   = pc;
            e.opr_b   = 32'd4;
            e.taken   = 1'b1;
            e.next_pc = (f.rs1_val + imm_i(f.inst)) & ~32'd1;
            e.gpr_we  = 1'b1;
        end
        OPC_BRANCH: begin
            bad      = (f3 == 3'd2) || (f3 == 3'd3);
            e.alu_op = alu_sub;
            e.taken  = branch_holds(f3, f.rs1_val, f.rs2_val);
            if (e.taken) begin
                e.next_pc = pc + imm_b(f.inst);
            end
        end
        OPC_LOAD: begin
            e.mem_op = load_op_of(f3);
            e.opr_b  = imm_i(f.inst);
            e.gpr_we = 1'b1;
            bad      = (e.mem_op == mem_none);
        end
        OPC_STORE: begin
            e.mem_op = store_op_of(f3);
            e.opr_b  = imm_s(f.inst);
            bad      = (e.mem_op == mem_none);
        end
        OPC_OP_IMM: begin
            e.alu_op = arith_op_of(f3, f.inst[30], 1'b0);
            e.opr_b  = imm_i(f.inst);
            e.gpr_we = 1'b1;
        end
        OPC_OP: begin
            e.alu_op = arith_op_of(f3, f.inst[30], 1'b1);
            e.gpr_we = 1'b1;
        end
        default: bad = 1'b1;
    endcase
    if (bad) begin                    // Plain fall-through word
        e.alu_op  = alu_add;
        e.mem_op  = mem_none;
        e.opr_a   = f.rs1_val;
        e.opr_b   = f.rs2_val;
        e.next_pc = pc + 32'd4;
        e.taken   = 1'b0;
        e.gpr_we  = 1'b0;
        e.illegal = 1'b1;
    end
    if (e.rd == 5'd0) begin
        e.gpr_we = 1'b0;
    end
    return e;
endfunction

`endif

// ==== dv/frontend_tb.sv ====
`timescale 1ns/100ps

module frontend_tb;
    import frontend_pkg::*;

    `include "frontend_model.svh"

    localparam int          NUM_INSTS  = 2000;
    localparam int          CLK_PERIOD = 100;
    localparam int          DRIVE_DLY  = 1;
    localparam logic [31:0] SEED       = 32'h02c6_fa64;

    logic       clk;
    logic       rst;
    logic       in_valid;
    logic       in_ready;
    fetch_pkt_t in_pkt;
    logic       out_valid;
    logic       out_ready;
    exec_pkt_t  out_pkt;

    exec_pkt_t       exp_q[$];
    logic [31:0]     inst_q[$];       // Instruction words, for error lines
    logic [XLEN-1:0] model_pc;
    int              sent;
    int              checked;
    int              stall_left;

    frontend UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Weighted opcode mix, rd forced to zero now and then
    function automatic logic [31:0] random_inst();
        logic [31:0] w;
        int unsigned pick;
        w    = $urandom();
        pick = $urandom_range(99);
        if (pick < 15)      w[6:0] = OPC_OP;
        else if (pick < 30) w[6:0] = OPC_OP_IMM;
        else if (pick < 40) w[6:0] = OPC_LOAD;
        else if (pick < 50) w[6:0] = OPC_STORE;
        else if (pick < 70) w[6:0] = OPC_BRANCH;
        else if (pick < 75) w[6:0] = OPC_JAL;
        else if (pick < 80) w[6:0] = OPC_JALR;
        else if (pick < 85) w[6:0] = OPC_LUI;
        else if (pick < 90) w[6:0] = OPC_AUIPC;
        else if (pick < 94) w[6:0] = 7'b1110011;   // CSR / system
        else if (pick < 97) w[6:0] = 7'b0001111;   // Fence
        else begin
            while (w[6:0] inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                                  OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP}) begin
                w[6:0] = 7'($urandom());
            end
        end
        if ($urandom_range(7) == 0) w[11:7] = 5'd0;
        return w;
    endfunction

    function automatic fetch_pkt_t random_fetch();
        fetch_pkt_t p;
        p.inst    = random_inst();
        p.rs1_val = $urandom();
        p.rs2_val = ($urandom_range(3) == 0) ? p.rs1_val : $urandom();
        return p;
    endfunction

    task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t: %s is %h, expected %h (inst %h, output #%0d)",
                     $time, what, got, exp, inst_q[0], checked);
            $display("SOME TESTS FAILED");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic record_input();
        exec_pkt_t e;
        e = expected_exec(in_pkt, model_pc);
        exp_q.push_back(e);
        inst_q.push_back(in_pkt.inst);
        model_pc = e.next_pc;
        sent++;
    endtask

    task automatic check_output();
        exec_pkt_t e;
        assert (exp_q.size() > 0) else begin
            $display("Output handshake at %0t with no instruction outstanding", $time);
            $display("SOME TESTS FAILED");
            $fatal(1, "Unexpected output");
        end
        e = exp_q[0];
        check_value("pc", out_pkt.pc, e.pc);
        check_value("next_pc", out_pkt.next_pc, e.next_pc);
        check_value("alu_op", 32'(out_pkt.alu_op), 32'(e.alu_op));
        check_value("mem_op", 32'(out_pkt.mem_op), 32'(e.mem_op));
        check_value("opr_a", out_pkt.opr_a, e.opr_a);
        check_value("opr_b", out_pkt.opr_b, e.opr_b);
        check_value("store_data", out_pkt.store_data, e.store_data);
        check_value("rd", 32'(out_pkt.rd), 32'(e.rd));
        check_value("gpr_we", 32'(out_pkt.gpr_we), 32'(e.gpr_we));
        check_value("illegal", 32'(out_pkt.illegal), 32'(e.illegal));
        check_value("taken", 32'(out_pkt.taken), 32'(e.taken));
        void'(exp_q.pop_front());
        void'(inst_q.pop_front());
        checked++;
    endtask

    task automatic drive_input();
        if (sent >= NUM_INSTS) begin
            in_valid = 1'b0;
        end else if ($urandom_range(4) == 0) begin
            in_valid = 1'b0;                    // Gap in the stream
        end else begin
            in_pkt   = random_fetch();
            in_valid = 1'b1;
        end
    endtask

    // Short random dips plus the odd long stall to fill the FIFO
    task automatic drive_ready();
        if (stall_left > 0) begin
            out_ready  = 1'b0;
            stall_left--;
        end else if ($urandom_range(49) == 0) begin
            out_ready  = 1'b0;
            stall_left = $urandom_range(15, 6);
        end else begin
            out_ready  = ($urandom_range(9) >= 3);
        end
    endtask

    initial begin
        logic accepted;
        logic delivered;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_pkt       = '0;
        out_ready    = 1'b0;
        sent         = 0;
        checked      = 0;
        stall_left   = 0;
        model_pc     = RESET_PC;
        void'($urandom(SEED));
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        assert (in_ready && !out_valid) else begin
            $display("ERR %0t: reset state in_ready %b out_valid %b, expected 1 and 0",
                     $time, in_ready, out_valid);
            $display("SOME TESTS FAILED");
            $fatal(1, "Reset state mismatch");
        end
        while (checked < NUM_INSTS) begin
            @(negedge clk);                     // Sample handshakes mid-cycle
            accepted  = in_valid && in_ready;
            delivered = out_valid && out_ready;
            if (accepted) record_input();
            if (delivered) check_output();
            @(posedge clk);
            #DRIVE_DLY;
            if (!in_valid || accepted) drive_input();
            drive_ready();
        end
        in_valid  = 1'b0;
        out_ready = 1'b1;
        repeat (10) begin
            @(negedge clk);
            assert (!out_valid) else begin
                $display("Extra output at %0t after all instructions were checked", $time);
                $display("SOME TESTS FAILED");
                $fatal(1, "Duplicate or spurious output");
            end
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

    initial begin
        #(NUM_INSTS * CLK_PERIOD * 10);
        $display("Watchdog timeout: outputs stalled with %0d of %0d instructions checked",
                 checked, NUM_INSTS);
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog timeout");
    end

endmodule

// ==== build.f ====
+incdir+dv
source/frontend_pkg.sv
source/inst_decoder.sv
source/decode_fifo.sv
source/pc_sequencer.sv
source/frontend.sv
dv/frontend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the frontend testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="SOME TESTS FAILED"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module frontend_tb -f build.f -o Vfrontend_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vfrontend_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

echo "Simulation passed"
exit 0
